//--- filelist.f
hw/pin_pkg.sv
hw/pin_bus_slave.sv
hw/pin_controller.sv
hw/pin_array_top.sv
tb/pin_array_checker.sv
tb/pin_array_tb.sv

//--- hw/pin_array_top.sv
`timescale 1ns/1ps

module pin_array_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  pin_pkg::addr_t      adr,
  input  pin_pkg::word_t      dat_w,
  output pin_pkg::word_t      dat_r,
  output logic                ack,
  output pin_pkg::chan_mask_t pins
);

  pin_pkg::chan_write_t [pin_pkg::NUM_CHAN-1:0] chan_wr;
  pin_pkg::chan_regs_t  [pin_pkg::NUM_CHAN-1:0] chan_regs;
  pin_pkg::chan_mask_t                          start;
  logic                                         abort;  // Shared by all channels.

  pin_bus_slave u_bus (
    .clk       (clk),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .dat_r     (dat_r),
    .ack       (ack),
    .chan_wr   (chan_wr),
    .start     (start),
    .abort     (abort),
    .chan_regs (chan_regs)
  );

  // One pulse generator per pin.
  for (genvar i = 0; i < pin_pkg::NUM_CHAN; i++) begin : g_chan
    pin_controller u_chan (
      .clk   (clk),
      .reset (reset),
      .wr    (chan_wr[i]),
      .start (start[i]),
      .abort (abort),
      .regs  (chan_regs[i]),
      .pin   (pins[i])
    );
  end

endmodule

//--- hw/pin_bus_slave.sv
`timescale 1ns/1ps

module pin_bus_slave (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        cyc,
  input  logic                                        stb,
  input  logic                                        we,
  input  pin_pkg::addr_t                              adr,
  input  pin_pkg::word_t                              dat_w,
  output pin_pkg::word_t                              dat_r,
  output logic                                        ack,
  output pin_pkg::chan_write_t [pin_pkg::NUM_CHAN-1:0] chan_wr,
  output pin_pkg::chan_mask_t                         start,
  output logic                                        abort,
  input  pin_pkg::chan_regs_t  [pin_pkg::NUM_CHAN-1:0] chan_regs
);

  logic                req;          // New transfer sampled on this edge.
  logic                hit_global;
  logic                hit_chan;
  logic                in_window;
  pin_pkg::addr_t      rel;
  pin_pkg::addr_t      ofs;
  pin_pkg::chan_idx_t  chan_idx;
  pin_pkg::reg_sel_e   reg_sel;
  pin_pkg::chan_regs_t sel_regs;
  pin_pkg::chan_mask_t busy_mask;
  pin_pkg::chan_mask_t done_mask;
  pin_pkg::word_t      rd_word;

  assign req = cyc && stb && !ack;  // A held request gets one ack per transfer.

  // Address decode.
  always_comb begin
    hit_global = (adr == pin_pkg::ADDR_GLOBAL_CMD);
    in_window  = (adr >= pin_pkg::CHAN_BASE) &&
                 (adr < pin_pkg::CHAN_BASE + pin_pkg::NUM_CHAN * pin_pkg::CHAN_STRIDE);
    rel        = adr - pin_pkg::CHAN_BASE;
    chan_idx   = pin_pkg::chan_idx_t'(rel / pin_pkg::CHAN_STRIDE);
    ofs        = rel % pin_pkg::CHAN_STRIDE;
    reg_sel    = pin_pkg::REG_DUTY;
    hit_chan   = 1'b0;
    case (ofs)
      pin_pkg::OFS_DUTY: begin
        reg_sel  = pin_pkg::REG_DUTY;
        hit_chan = in_window;
      end
      pin_pkg::OFS_ANTI: begin
        reg_sel  = pin_pkg::REG_ANTI;
        hit_chan = in_window;
      end
      pin_pkg::OFS_CYCLES: begin
        reg_sel  = pin_pkg::REG_CYCLES;
        hit_chan = in_window;
      end
      pin_pkg::OFS_CTRL: begin
        reg_sel  = pin_pkg::REG_CTRL;
        hit_chan = in_window;
      end
      default: hit_chan = 1'b0;  // Holes in the window read 0.
    endcase
  end

  // Register writes land on the edge that raises ack.
  always_comb begin
    for (int i = 0; i < pin_pkg::NUM_CHAN; i++) begin
      chan_wr[i].valid = req && we && hit_chan && (chan_idx == i);
      chan_wr[i].sel   = reg_sel;
      chan_wr[i].data  = dat_w;
      busy_mask[i]     = chan_regs[i].busy;
      done_mask[i]     = chan_regs[i].done;
    end
  end

  // Read mux.
  always_comb begin
    sel_regs = chan_regs[chan_idx];
    rd_word  = '0;
    if (hit_global) begin
      rd_word[pin_pkg::NUM_CHAN-1:0]                 = busy_mask;
      rd_word[2*pin_pkg::NUM_CHAN-1:pin_pkg::NUM_CHAN] = done_mask;
    end else if (hit_chan) begin
      case (reg_sel)
        pin_pkg::REG_DUTY:   rd_word = sel_regs.duty;
        pin_pkg::REG_ANTI:   rd_word = sel_regs.anti;
        pin_pkg::REG_CYCLES: rd_word = sel_regs.cycles;
        default: begin
          rd_word[pin_pkg::CTRL_RUN_INF_BIT] = sel_regs.run_inf;
          rd_word[pin_pkg::CTRL_BUSY_BIT]    = sel_regs.busy;
          rd_word[pin_pkg::CTRL_DONE_BIT]    = sel_regs.done;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ack   <= 1'b0;
      start <= '0;
      abort <= 1'b0;
    end else begin
      ack   <= req;
      start <= '0;   // Command pulses last one cycle.
      abort <= 1'b0;
      if (req && we && hit_global) begin
        if (dat_w[pin_pkg::ABORT_BIT])
          abort <= 1'b1;  // Abort overrides any start bits.
        else
          start <= dat_w[pin_pkg::NUM_CHAN-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req)
      dat_r <= rd_word;  // Valid during the ack cycle.
  end

endmodule

//--- hw/pin_controller.sv
`timescale 1ns/1ps

module pin_controller (
  input  logic                 clk,
  input  logic                 reset,
  input  pin_pkg::chan_write_t wr,
  input  logic                 start,
  input  logic                 abort,
  output pin_pkg::chan_regs_t  regs,
  output logic                 pin
);

  // Bus visible registers.
  pin_pkg::tick_t duty;
  pin_pkg::tick_t anti;
  pin_pkg::tick_t cycles;
  logic           run_inf;

  // Copies taken at start so bus writes do not disturb a run.
  pin_pkg::tick_t shd_duty;
  pin_pkg::tick_t shd_anti;
  logic           shd_inf;

  // Down-counters of the running sequence.
  pin_pkg::tick_t cnt_high;
  pin_pkg::tick_t cnt_low;
  pin_pkg::tick_t cnt_per;

  pin_pkg::seq_state_e state;
  pin_pkg::seq_state_e next_state;
  logic                done;
  logic                launch;
  logic                high_end;
  logic                low_end;
  logic                last_period;

  always_ff @(posedge clk) begin
    if (reset) begin
      duty    <= '0;
      anti    <= '0;
      cycles  <= '0;
      run_inf <= 1'b0;
    end else if (wr.valid) begin
      case (wr.sel)
        pin_pkg::REG_DUTY:   duty    <= wr.data;
        pin_pkg::REG_ANTI:   anti    <= wr.data;
        pin_pkg::REG_CYCLES: cycles  <= wr.data;
        default:             run_inf <= wr.data[pin_pkg::CTRL_RUN_INF_BIT];
      endcase
    end
  end

  always_comb begin
    launch      = start && !abort && (state == pin_pkg::IDLE);  // Start while busy is dropped.
    high_end    = (state == pin_pkg::HIGH) && (cnt_high == '0);
    low_end     = (state == pin_pkg::LOW) && (cnt_low == '0);
    last_period = !shd_inf && (cnt_per == '0);
  end

  // Sequencer next state.
  always_comb begin
    next_state = state;
    if (abort) begin
      next_state = pin_pkg::IDLE;
    end else begin
      case (state)
        pin_pkg::IDLE: begin
          if (launch)
            next_state = pin_pkg::HIGH;
        end
        pin_pkg::HIGH: begin
          if (high_end)
            next_state = pin_pkg::LOW;
        end
        pin_pkg::LOW: begin
          if (low_end)
            next_state = last_period ? pin_pkg::IDLE : pin_pkg::HIGH;
        end
        default: next_state = pin_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= pin_pkg::IDLE;
      done  <= 1'b0;
    end else begin
      state <= next_state;
      if (launch)
        done <= 1'b0;
      else if (low_end && last_period && !abort)
        done <= 1'b1;  // Only a natural finish sets it.
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      shd_duty <= duty;
      shd_anti <= anti;
      shd_inf  <= run_inf;
      cnt_high <= duty;
      cnt_low  <= anti;
      cnt_per  <= cycles;
    end else if (state == pin_pkg::HIGH) begin
      if (!high_end)
        cnt_high <= cnt_high - 1'b1;
    end else if (state == pin_pkg::LOW) begin
      if (!low_end) begin
        cnt_low <= cnt_low - 1'b1;
      end else begin
        // End of one period, rearm both phases.
        cnt_high <= shd_duty;
        cnt_low  <= shd_anti;
        if (!shd_inf && !last_period)
          cnt_per <= cnt_per - 1'b1;
      end
    end
  end

  assign pin = (state == pin_pkg::HIGH);

  always_comb begin
    regs.duty    = duty;
    regs.anti    = anti;
    regs.cycles  = cycles;
    regs.run_inf = run_inf;
    regs.busy    = (state != pin_pkg::IDLE);
    regs.done    = done;
  end

endmodule

//--- hw/pin_pkg.sv
package pin_pkg;

  // Bus and timing widths.
  typedef logic [20:0] addr_t;   // Wishbone byte address.
  typedef logic [15:0] word_t;   // Bus data word.
  typedef logic [15:0] tick_t;   // Phase length or period count in clocks.

  localparam int NUM_CHAN = 4;

  typedef logic [NUM_CHAN-1:0]         chan_mask_t;  // One bit per channel.
  typedef logic [$clog2(NUM_CHAN)-1:0] chan_idx_t;

  // Register map.
  localparam addr_t ADDR_GLOBAL_CMD = 21'd0;
  localparam addr_t CHAN_BASE       = 21'd16;
  localparam addr_t CHAN_STRIDE     = 21'd16;

  // Offsets inside one channel window.
  localparam addr_t OFS_DUTY   = 21'd0;
  localparam addr_t OFS_ANTI   = 21'd4;
  localparam addr_t OFS_CYCLES = 21'd8;
  localparam addr_t OFS_CTRL   = 21'd12;

  localparam int ABORT_BIT = 15;  // Global command bit that stops every channel.

  // Bit positions in the channel ctrl word.
  localparam int CTRL_RUN_INF_BIT = 0;
  localparam int CTRL_BUSY_BIT    = 1;
  localparam int CTRL_DONE_BIT    = 2;

  typedef enum logic [1:0] {
    REG_DUTY,
    REG_ANTI,
    REG_CYCLES,
    REG_CTRL
  } reg_sel_e;

  typedef enum logic [1:0] {
    IDLE,
    HIGH,
    LOW
  } seq_state_e;

  // One write to one channel register.
  typedef struct packed {
    logic     valid;
    reg_sel_e sel;
    word_t    data;
  } chan_write_t;

  // Channel state as seen by the bus.
  typedef struct packed {
    tick_t duty;
    tick_t anti;
    tick_t cycles;
    logic  run_inf;
    logic  busy;
    logic  done;
  } chan_regs_t;

endpackage

//--- tb/pin_array_checker.sv
`timescale 1ns/1ps

module pin_array_checker (
  input logic clk,
  input logic reset,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic pin,
  input logic busy,
  input logic done
);

  logic fail_seen = 1'b0;  // Sticky, read by the testbench.

  // A registered ack answers the request of the cycle before.
  ack_follows_request: assert property (@(posedge clk) disable iff (reset)
    ack |-> $past(cyc && stb))
    else begin
      fail_seen = 1'b1;
      $error("ack raised without a request in the previous cycle");
    end

  ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
    ack |=> !ack)
    else begin
      fail_seen = 1'b1;
      $error("ack held high for two cycles");
    end

  // The pin is only driven inside a run.
  pin_only_when_busy: assert property (@(posedge clk) disable iff (reset)
    !busy |-> !pin)
    else begin
      fail_seen = 1'b1;
      $error("pin high while the channel is idle");
    end

  busy_done_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(busy && done))
    else begin
      fail_seen = 1'b1;
      $error("busy and done both set");
    end

endmodule

// Bus side, channel inputs tied low.
bind pin_bus_slave pin_array_checker u_check (
  .clk   (clk),
  .reset (reset),
  .cyc   (cyc),
  .stb   (stb),
  .ack   (ack),
  .pin   (1'b0),
  .busy  (1'b0),
  .done  (1'b0)
);

bind pin_controller pin_array_checker u_check (
  .clk   (clk),
  .reset (reset),
  .cyc   (1'b0),
  .stb   (1'b0),
  .ack   (1'b0),
  .pin   (pin),
  .busy  (regs.busy),
  .done  (regs.done)
);

//--- tb/pin_array_tb.sv
`timescale 1ns/1ps

module pin_array_tb;

  localparam int BUS_TIMEOUT = 20;    // Clocks to wait for ack.
  localparam int PIN_TIMEOUT = 2000;  // Clocks to wait on a pin level.
  localparam int POLL_LIMIT  = 200;   // Status reads before giving up.
  localparam int RUN_LIMIT   = 1000;  // Period cap for finite runs.

  // Expected waveform of one channel.
  typedef struct packed {
    pin_pkg::tick_t high_len;
    pin_pkg::tick_t low_len;
    pin_pkg::tick_t periods;
  } wave_t;

  logic                clk = 1'b0;
  logic                reset;
  logic                cyc;
  logic                stb;
  logic                we;
  pin_pkg::addr_t      adr;
  pin_pkg::word_t      dat_w;
  pin_pkg::word_t      dat_r;
  logic                ack;
  pin_pkg::chan_mask_t pins;

  logic [31:0]    rng_state = 32'd47;
  wave_t          exp_wave    [pin_pkg::NUM_CHAN];
  int             got_periods [pin_pkg::NUM_CHAN];
  pin_pkg::tick_t r_duty      [pin_pkg::NUM_CHAN];
  pin_pkg::tick_t r_anti      [pin_pkg::NUM_CHAN];
  pin_pkg::tick_t r_cycles    [pin_pkg::NUM_CHAN];

  always #5 clk = ~clk;

  pin_array_top u_pin_array_top (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack),
    .pins  (pins)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input pin_pkg::word_t exp,
                            input pin_pkg::word_t got);
    if (got !== exp)
      stop_with_failure($sformatf("mismatch %s expected 0x%h actual 0x%h", name, exp, got));
  endtask

  task automatic check_tick(input string name, input pin_pkg::tick_t exp,
                            input pin_pkg::tick_t got);
    if (got !== exp)
      stop_with_failure($sformatf("mismatch %s expected %0d actual %0d", name, exp, got));
  endtask

  task automatic check_mask(input string name, input pin_pkg::chan_mask_t exp,
                            input pin_pkg::chan_mask_t got);
    if (got !== exp)
      stop_with_failure($sformatf("mismatch %s expected %b actual %b", name, exp, got));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_small(output pin_pkg::tick_t v);
    rng_state = xorshift(rng_state);
    v = pin_pkg::tick_t'(rng_state[2:0]);  // 0 to 7.
  endtask

  // High lasts duty+1, low anti+1, and a run has cycles+1 periods.
  function automatic wave_t pin_wave(input pin_pkg::tick_t duty, input pin_pkg::tick_t anti,
                                     input pin_pkg::tick_t cycles);
    wave_t w;
    w.high_len = duty + 1'b1;
    w.low_len  = anti + 1'b1;
    w.periods  = cycles + 1'b1;
    return w;
  endfunction

  function automatic pin_pkg::addr_t chan_addr(input int ch, input pin_pkg::addr_t ofs);
    return pin_pkg::CHAN_BASE + pin_pkg::addr_t'(ch) * pin_pkg::CHAN_STRIDE + ofs;
  endfunction

  function automatic logic chan_busy(input int ch);
    return u_pin_array_top.chan_regs[ch].busy;
  endfunction

  function automatic logic assertions_failed();
    return u_pin_array_top.u_bus.u_check.fail_seen ||
           u_pin_array_top.g_chan[0].u_chan.u_check.fail_seen ||
           u_pin_array_top.g_chan[1].u_chan.u_check.fail_seen ||
           u_pin_array_top.g_chan[2].u_chan.u_check.fail_seen ||
           u_pin_array_top.g_chan[3].u_chan.u_check.fail_seen;
  endfunction

  always @(posedge clk) begin
    if (assertions_failed())
      stop_with_failure("a bound assertion on the bus or a channel failed");
  end

  task automatic bus_write(input pin_pkg::addr_t a, input pin_pkg::word_t d);
    int waited;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= a;
    dat_w <= d;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > BUS_TIMEOUT)
        stop_with_failure($sformatf("no ack for the write to address 0x%h", a));
    end while (!ack);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic bus_read(input pin_pkg::addr_t a, output pin_pkg::word_t d);
    int waited;
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > BUS_TIMEOUT)
        stop_with_failure($sformatf("no ack for the read of address 0x%h", a));
    end while (!ack);
    d = dat_r;  // Valid while ack is high.
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  task automatic read_status(output pin_pkg::chan_mask_t busy, output pin_pkg::chan_mask_t done);
    pin_pkg::word_t w;
    bus_read(pin_pkg::ADDR_GLOBAL_CMD, w);
    busy = w[pin_pkg::NUM_CHAN-1:0];
    done = w[2*pin_pkg::NUM_CHAN-1:pin_pkg::NUM_CHAN];
  endtask

  task automatic wait_idle(input pin_pkg::chan_mask_t mask, input string name);
    pin_pkg::chan_mask_t busy;
    pin_pkg::chan_mask_t done;
    int                  polls;
    polls = 0;
    do begin
      read_status(busy, done);
      polls++;
      if (polls > POLL_LIMIT)
        stop_with_failure($sformatf("%s: channels stayed busy", name));
    end while ((busy & mask) != '0);
  endtask

  task automatic wait_pin(input int ch, input logic level, input string name);
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > PIN_TIMEOUT)
        stop_with_failure($sformatf("%s: pin %0d never reached %b", name, ch, level));
    end while (pins[ch] !== level);
  endtask

  task automatic load_channel(input int ch, input pin_pkg::tick_t duty,
                              input pin_pkg::tick_t anti, input pin_pkg::tick_t cycles,
                              input logic run_inf);
    bus_write(chan_addr(ch, pin_pkg::OFS_DUTY), duty);
    bus_write(chan_addr(ch, pin_pkg::OFS_ANTI), anti);
    bus_write(chan_addr(ch, pin_pkg::OFS_CYCLES), cycles);
    bus_write(chan_addr(ch, pin_pkg::OFS_CTRL), pin_pkg::word_t'(run_inf));
  endtask

  // Measures high and low runs of one pin and compares every period.
  task automatic watch_run(input int ch, input string name, input wave_t exp,
                           input int stop_after, output int periods);
    pin_pkg::tick_t high_len;
    pin_pkg::tick_t low_len;
    periods = 0;
    wait_pin(ch, 1'b1, name);
    while (periods < stop_after) begin
      high_len = '0;
      low_len  = '0;
      while (pins[ch]) begin
        high_len++;
        @(posedge clk);
        if (high_len > PIN_TIMEOUT)
          stop_with_failure($sformatf("%s: pin %0d stuck high", name, ch));
      end
      while (!pins[ch] && chan_busy(ch)) begin  // Last low phase ends with busy.
        low_len++;
        @(posedge clk);
        if (low_len > PIN_TIMEOUT)
          stop_with_failure($sformatf("%s: pin %0d stuck low while busy", name, ch));
      end
      check_tick({name, " high length"}, exp.high_len, high_len);
      check_tick({name, " low length"}, exp.low_len, low_len);
      periods++;
      if (!chan_busy(ch))
        break;
    end
  endtask

  initial begin
    pin_pkg::word_t      rd;
    pin_pkg::chan_mask_t busy;
    pin_pkg::chan_mask_t done;
    reset = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    check_mask("reset pins", '0, pins);
    read_status(busy, done);
    check_mask("reset busy", '0, busy);
    check_mask("reset done", '0, done);

    // Register read-back. Only bit 0 of ctrl is stored.
    for (int ch = 0; ch < pin_pkg::NUM_CHAN; ch++) begin
      bus_write(chan_addr(ch, pin_pkg::OFS_DUTY), pin_pkg::word_t'(16'h1000 + ch));
      bus_write(chan_addr(ch, pin_pkg::OFS_ANTI), pin_pkg::word_t'(16'h2000 + ch));
      bus_write(chan_addr(ch, pin_pkg::OFS_CYCLES), pin_pkg::word_t'(16'h3000 + ch));
      bus_write(chan_addr(ch, pin_pkg::OFS_CTRL), pin_pkg::word_t'(16'h00f0 + ch % 2));
    end
    for (int ch = 0; ch < pin_pkg::NUM_CHAN; ch++) begin
      bus_read(chan_addr(ch, pin_pkg::OFS_DUTY), rd);
      check_word($sformatf("readback ch%0d duty", ch), pin_pkg::word_t'(16'h1000 + ch), rd);
      bus_read(chan_addr(ch, pin_pkg::OFS_ANTI), rd);
      check_word($sformatf("readback ch%0d anti", ch), pin_pkg::word_t'(16'h2000 + ch), rd);
      bus_read(chan_addr(ch, pin_pkg::OFS_CYCLES), rd);
      check_word($sformatf("readback ch%0d cycles", ch), pin_pkg::word_t'(16'h3000 + ch), rd);
      bus_read(chan_addr(ch, pin_pkg::OFS_CTRL), rd);
      check_word($sformatf("readback ch%0d ctrl", ch), pin_pkg::word_t'(ch % 2), rd);
      bus_write(chan_addr(ch, pin_pkg::OFS_CTRL), '0);
    end
    bus_read(21'h000100, rd);
    check_word("unmapped read above windows", '0, rd);
    bus_read(21'h000004, rd);
    check_word("unmapped read below windows", '0, rd);

    // Single finite run on channel 0.
    load_channel(0, 16'd2, 16'd3, 16'd2, 1'b0);
    exp_wave[0] = pin_wave(16'd2, 16'd3, 16'd2);
    fork
      watch_run(0, "single run", exp_wave[0], RUN_LIMIT, got_periods[0]);
      bus_write(pin_pkg::ADDR_GLOBAL_CMD, 16'h0001);
    join
    check_tick("single run periods", exp_wave[0].periods, pin_pkg::tick_t'(got_periods[0]));
    read_status(busy, done);
    check_mask("single run busy", 4'b0000, busy);
    check_mask("single run done", 4'b0001, done);

    // Concurrent random runs started by one command.
    for (int ch = 0; ch < pin_pkg::NUM_CHAN; ch++) begin
      draw_small(r_duty[ch]);
      draw_small(r_anti[ch]);
      draw_small(r_cycles[ch]);
      load_channel(ch, r_duty[ch], r_anti[ch], r_cycles[ch], 1'b0);
      exp_wave[ch] = pin_wave(r_duty[ch], r_anti[ch], r_cycles[ch]);
    end
    for (int ch = 0; ch < pin_pkg::NUM_CHAN; ch++) begin
      fork
        automatic int idx = ch;
        watch_run(idx, $sformatf("random ch%0d", idx), exp_wave[idx], RUN_LIMIT,
                  got_periods[idx]);
      join_none
    end
    bus_write(pin_pkg::ADDR_GLOBAL_CMD, 16'h000f);
    wait fork;
    for (int ch = 0; ch < pin_pkg::NUM_CHAN; ch++)
      check_tick($sformatf("random ch%0d periods", ch), exp_wave[ch].periods,
                 pin_pkg::tick_t'(got_periods[ch]));
    read_status(busy, done);
    check_mask("random busy", 4'b0000, busy);
    check_mask("random done", 4'b1111, done);

    // Run forever on channel 2 and abort it.
    load_channel(2, 16'd1, 16'd1, 16'd1, 1'b1);
    exp_wave[2] = pin_wave(16'd1, 16'd1, 16'd1);
    fork
      watch_run(2, "run forever", exp_wave[2], int'(exp_wave[2].periods) + 2, got_periods[2]);
      bus_write(pin_pkg::ADDR_GLOBAL_CMD, 16'h0004);
    join
    check_tick("run forever periods", exp_wave[2].periods + 2'd2,
               pin_pkg::tick_t'(got_periods[2]));
    read_status(busy, done);
    check_mask("run forever busy", 4'b0100, busy);
    bus_write(pin_pkg::ADDR_GLOBAL_CMD, 16'h1 << pin_pkg::ABORT_BIT);
    wait_idle(4'b0100, "abort");
    check_mask("abort pins", '0, pins);
    read_status(busy, done);
    check_mask("abort busy", 4'b0000, busy);
    check_mask("abort done", 4'b1011, done);  // Channel 2 lost its done at start.
    bus_write(chan_addr(2, pin_pkg::OFS_CTRL), '0);

    // Second start and a duty write while channel 1 runs.
    load_channel(1, 16'd3, 16'd2, 16'd2, 1'b0);
    exp_wave[1] = pin_wave(16'd3, 16'd2, 16'd2);
    fork
      watch_run(1, "busy run", exp_wave[1], RUN_LIMIT, got_periods[1]);
      begin
        bus_write(pin_pkg::ADDR_GLOBAL_CMD, 16'h0002);
        wait_pin(1, 1'b1, "busy run start");
        bus_write(chan_addr(1, pin_pkg::OFS_DUTY), 16'd6);
        bus_write(pin_pkg::ADDR_GLOBAL_CMD, 16'h0002);
      end
    join
    check_tick("busy run periods", exp_wave[1].periods, pin_pkg::tick_t'(got_periods[1]));
    bus_read(chan_addr(1, pin_pkg::OFS_DUTY), rd);
    check_word("busy run stored duty", 16'd6, rd);
    exp_wave[1] = pin_wave(16'd6, 16'd2, 16'd2);
    fork
      watch_run(1, "next run", exp_wave[1], RUN_LIMIT, got_periods[1]);
      bus_write(pin_pkg::ADDR_GLOBAL_CMD, 16'h0002);
    join
    check_tick("next run periods", exp_wave[1].periods, pin_pkg::tick_t'(got_periods[1]));
    read_status(busy, done);
    check_mask("next run busy", 4'b0000, busy);
    check_mask("next run done", 4'b1011, done);

    if (!assertions_failed()) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_with_failure("a bound assertion on the bus or a channel failed");
    end
  end

endmodule
